// ==== all.f ====
rtl/lsu_pkg.sv
rtl/mem_req_capture.sv
rtl/load_sequencer.sv
rtl/load_extend.sv
rtl/mem_stage.sv
dv/mem_stage_asserts.sv
dv/mem_stage_tb.sv

// ==== dv/mem_stage_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage_asserts (
    input wire logic             clk,
    input wire logic             rst_n,
    input wire logic             ex_valid,
    input wire logic             busy,
    input wire logic             rd_req_valid,
    input wire lsu_pkg::rd_req_t rd_req,
    input wire logic             rd_ack,
    input wire logic             wb_valid
);

    // assertion failures so far
    int fail_count = 0;

    // request held with a stable payload until the address is accepted
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid && !rd_ack |=> rd_req_valid && $stable(rd_req))
        else begin
            fail_count++;
            $error("read request dropped or changed before rd_ack");
        end

    // one request per load, gone after the accept
    req_drop: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid && rd_ack |=> !rd_req_valid)
        else begin
            fail_count++;
            $error("read request still valid in the cycle after rd_ack");
        end

    // busy rises the cycle after the strobe
    busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid |=> busy)
        else begin
            fail_count++;
            $error("busy low in the cycle after ex_valid");
        end

    // writeback closes the busy window
    busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> busy ##1 !busy)
        else begin
            fail_count++;
            $error("busy window does not end on the writeback cycle");
        end

endmodule

`default_nettype wire

// ==== dv/mem_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage_tb;

    localparam int n_ops      = 200;
    localparam int cyc_per_op = 64;
    localparam int clk_period = 20;
    localparam logic [31:0] seed = 32'h96bf5e67;

    logic             clk;
    logic             rst_n;
    logic             ex_valid;
    lsu_pkg::ex_op_t  ex_op;
    logic             busy;
    logic             rd_req_valid;
    lsu_pkg::rd_req_t rd_req;
    logic             rd_ack;
    logic             rd_rsp_valid;
    lsu_pkg::rd_rsp_t rd_rsp;
    logic             wb_valid;
    lsu_pkg::wb_t     wb;

    // lfsr state and the backing memory, 256 doublewords
    logic [31:0] lfsr_q;
    logic [63:0] mem [0:255];

    int mismatch_count;
    int other_count;
    int op_count;

    mem_stage dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .busy         (busy),
        .rd_req_valid (rd_req_valid),
        .rd_req       (rd_req),
        .rd_ack       (rd_ack),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp       (rd_rsp),
        .wb_valid     (wb_valid),
        .wb           (wb)
    );

    bind mem_stage mem_stage_asserts asserts_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .busy         (busy),
        .rd_req_valid (rd_req_valid),
        .rd_req       (rd_req),
        .rd_ack       (rd_ack),
        .wb_valid     (wb_valid)
    );

    always #(clk_period / 2) clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic int access_bytes(input lsu_pkg::load_kind_t kind);
        case (kind)
            lsu_pkg::lb, lsu_pkg::lbu: return 1;
            lsu_pkg::lh, lsu_pkg::lhu: return 2;
            lsu_pkg::lw, lsu_pkg::lwu: return 4;
            default: return 8;
        endcase
    endfunction

    // aligned base plus a doubleword step and the lane
    function automatic lsu_pkg::ex_op_t make_op(input lsu_pkg::load_kind_t kind,
                                                input logic [2:0] lane);
        lsu_pkg::ex_op_t op;
        logic [63:0] r;
        op.kind = kind;
        r = take_bits(64);
        op.base = {r[63:3], 3'b000};
        r = take_bits(8);
        op.offset = {r[60:0], lane};
        op.alu_res = take_bits(64);
        return op;
    endfunction

    // expected writeback, gathered byte by byte from the lane
    function automatic lsu_pkg::wb_t model_wb(input lsu_pkg::ex_op_t op, input logic [63:0] beat);
        lsu_pkg::wb_t want;
        logic [63:0] addr;
        logic sign;
        int nb;
        int i;
        addr = op.base + op.offset;
        nb = access_bytes(op.kind);
        want.data = '0;
        want.from_mem = (op.kind != lsu_pkg::none);
        if (!want.from_mem) begin
            want.data = op.alu_res;
        end else begin
            for (i = 0; i < nb; i++) begin
                want.data[8*i +: 8] = beat[8*(addr[2:0] + i) +: 8];
            end
            // only the plain kinds copy the top bit up
            sign = want.data[8*nb-1] && (op.kind inside {lsu_pkg::lb, lsu_pkg::lh, lsu_pkg::lw});
            for (i = nb; i < 8; i++) begin
                want.data[8*i +: 8] = {8{sign}};
            end
        end
        return want;
    endfunction

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            mismatch_count++;
            $display("MISMATCH %0t %s: got %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_req(input lsu_pkg::rd_req_t got, input lsu_pkg::rd_req_t want);
        if (got !== want) begin
            mismatch_count++;
            $display("MISMATCH %0t rd_req: got addr=%h id=%h, expected addr=%h id=%h",
                     $time, got.addr, got.id, want.addr, want.id);
        end
    endtask

    task automatic check_wb(input lsu_pkg::wb_t got, input lsu_pkg::wb_t want);
        if (got !== want) begin
            mismatch_count++;
            $display("MISMATCH %0t wb: got data=%h from_mem=%b, expected data=%h from_mem=%b",
                     $time, got.data, got.from_mem, want.data, want.from_mem);
        end
    endtask

    // one op from the ex strobe to its writeback, cycle 0 is the strobe
    task automatic run_op(input lsu_pkg::ex_op_t op);
        lsu_pkg::rd_req_t want_req;
        lsu_pkg::wb_t     want_wb;
        logic [63:0] addr;
        logic [63:0] req_addr;
        logic [63:0] r;
        logic        is_load;
        int ack_cyc;
        int rsp_cyc;
        int n_foreign;
        int wb_cyc;
        int cyc;
        int n;
        addr = op.base + op.offset;
        is_load = (op.kind != lsu_pkg::none);
        want_req.addr = {addr[63:3], 3'b000};
        want_req.id = lsu_pkg::mem_id;
        want_wb = model_wb(op, mem[addr[10:3]]);
        ack_cyc = 2 + int'(take_bits(2));
        n_foreign = int'(take_bits(2));
        // idle cycles, then the foreign responses, then ours
        rsp_cyc = ack_cyc + 1 + int'(take_bits(2)) + n_foreign;
        wb_cyc = is_load ? rsp_cyc + 1 : 2;
        req_addr = '0;
        @(posedge clk);
        #1;
        if (busy) begin
            other_count++;
            $display("%0t: stage still busy when the next operation is due", $time);
            for (n = 0; n < 32 && busy; n++) begin
                @(posedge clk);
                #1;
            end
        end
        ex_valid = 1'b1;
        ex_op = op;
        op_count++;
        for (cyc = 1; cyc <= wb_cyc; cyc++) begin
            @(posedge clk);
            #1;
            ex_valid = 1'b0;
            rd_ack = is_load && (cyc == ack_cyc);
            rd_rsp_valid = 1'b0;
            if (is_load && cyc >= rsp_cyc - n_foreign && cyc < rsp_cyc) begin
                // fetch traffic, any id but ours
                r = take_bits(lsu_pkg::id_w);
                rd_rsp_valid = 1'b1;
                rd_rsp.id = r[lsu_pkg::id_w-1:0];
                if (rd_rsp.id == lsu_pkg::mem_id) begin
                    rd_rsp.id = rd_rsp.id ^ 1;
                end
                rd_rsp.data = take_bits(64);
            end
            if (is_load && cyc == rsp_cyc) begin
                rd_rsp_valid = 1'b1;
                rd_rsp.id = lsu_pkg::mem_id;
                rd_rsp.data = mem[req_addr[10:3]];
            end
            @(negedge clk);
            check_flag("busy", busy, 1'b1);
            check_flag("wb_valid", wb_valid, cyc == wb_cyc);
            check_flag("rd_req_valid", rd_req_valid, is_load && cyc >= 2 && cyc <= ack_cyc);
            if (rd_req_valid) begin
                check_req(rd_req, want_req);
                req_addr = rd_req.addr;
            end
            if (wb_valid) begin
                check_wb(wb, want_wb);
            end
        end
    endtask

    initial begin
        lsu_pkg::load_kind_t kind;
        logic [63:0] r;
        int k;
        int lane;
        int nb;
        int total;
        clk = 1'b0;
        rst_n = 1'b0;
        ex_valid = 1'b0;
        ex_op = '0;
        rd_ack = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp = '0;
        mismatch_count = 0;
        other_count = 0;
        op_count = 0;
        lfsr_q = seed;
        for (k = 0; k < 256; k++) begin
            mem[k] = take_bits(64);
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("rd_req_valid", rd_req_valid, 1'b0);
        check_flag("wb_valid", wb_valid, 1'b0);
        // non-load right out of reset
        run_op(make_op(lsu_pkg::none, 3'd0));
        // every load kind at every legal lane
        for (k = 0; k < 7; k++) begin
            kind = lsu_pkg::load_kind_t'(k);
            nb = access_bytes(kind);
            for (lane = 0; lane < 8; lane += nb) begin
                run_op(make_op(kind, lane[2:0]));
            end
        end
        // random mix, back to back or one idle cycle apart
        while (op_count < n_ops) begin
            r = take_bits(3);
            kind = lsu_pkg::load_kind_t'(r[2:0]);
            nb = access_bytes(kind);
            r = take_bits(3) & (64'd8 - nb);
            if (take_bits(1) != 0) begin
                @(posedge clk);
            end
            run_op(make_op(kind, r[2:0]));
        end
        total = mismatch_count + other_count + dut_i.asserts_i.fail_count;
        $display("%0d ops, errors: %0d mismatch, %0d other, %0d assertion",
                 op_count, mismatch_count, other_count, dut_i.asserts_i.fail_count);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // every op fits in 64 cycles with room to spare
    initial begin
        #((n_ops * cyc_per_op + 10) * clk_period);
        $display("%0t: run did not finish within the time allowed for %0d ops", $time, n_ops);
        $display("%0d ops, errors: %0d mismatch, %0d other, %0d assertion",
                 op_count, mismatch_count, other_count + 1, dut_i.asserts_i.fail_count);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/load_extend.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_extend (
    input  wire logic                     done,
    input  wire lsu_pkg::mem_op_t         op,
    input  wire logic [lsu_pkg::xlen-1:0] beat,
    output logic                          wb_valid,
    output lsu_pkg::wb_t                  wb
);

    // byte lane inside the beat
    logic [lsu_pkg::off_w-1:0] lane;

    // beat shifted so the addressed byte sits at bit 0
    logic [lsu_pkg::xlen-1:0] lane_data;

    // data after extension or alu pass-through
    logic [lsu_pkg::xlen-1:0] wb_data;

    assign lane      = op.addr[lsu_pkg::off_w-1:0];
    assign lane_data = beat >> {lane, 3'b000};

    // extension by kind
    always_comb begin
        case (op.kind)
            lsu_pkg::lb: begin
                wb_data = {{(lsu_pkg::xlen-8){lane_data[7]}}, lane_data[7:0]};
            end
            lsu_pkg::lh: begin
                wb_data = {{(lsu_pkg::xlen-16){lane_data[15]}}, lane_data[15:0]};
            end
            lsu_pkg::lw: begin
                wb_data = {{(lsu_pkg::xlen-32){lane_data[31]}}, lane_data[31:0]};
            end
            // full beat, lane is zero for an aligned ld
            lsu_pkg::ld: begin
                wb_data = lane_data;
            end
            lsu_pkg::lbu: begin
                wb_data = {{(lsu_pkg::xlen-8){1'b0}}, lane_data[7:0]};
            end
            lsu_pkg::lhu: begin
                wb_data = {{(lsu_pkg::xlen-16){1'b0}}, lane_data[15:0]};
            end
            lsu_pkg::lwu: begin
                wb_data = {{(lsu_pkg::xlen-32){1'b0}}, lane_data[31:0]};
            end
            // not a load, alu result goes through
            lsu_pkg::none: begin
                wb_data = op.alu_res;
            end
            default: begin
                wb_data = '0;
            end
        endcase
    end

    // writeback select
    always_comb begin
        wb.data     = wb_data;
        wb.from_mem = (op.kind != lsu_pkg::none);
    end

    // record is valid for the single done cycle
    assign wb_valid = done;

endmodule

`default_nettype wire

// ==== rtl/load_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_sequencer (
    input  wire logic             clk,
    input  wire logic             rst_n,
    // captured op from the input side
    input  wire logic             req_valid,
    input  wire lsu_pkg::mem_op_t req,
    // shared read bus
    output logic                  rd_req_valid,
    output lsu_pkg::rd_req_t      rd_req,
    input  wire logic             rd_ack,
    input  wire logic             rd_rsp_valid,
    input  wire lsu_pkg::rd_rsp_t rd_rsp,
    // status toward execute and the output side
    output logic                  busy,
    output logic                  done,
    output logic [lsu_pkg::xlen-1:0] beat,
    output lsu_pkg::mem_op_t      op
);

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_req  = 2'd1,
        st_wait = 2'd2,
        st_done = 2'd3
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_nxt;

    // held op and returned beat
    lsu_pkg::mem_op_t         op_q;
    logic [lsu_pkg::xlen-1:0] beat_q;

    // response is ours and we are waiting for it
    logic rsp_hit;

    assign rsp_hit = (state == st_wait) && rd_rsp_valid && (rd_rsp.id == lsu_pkg::mem_id);

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req_valid) begin
                    // non-loads go straight to writeback
                    if (req.kind == lsu_pkg::none) begin
                        state_nxt = st_done;
                    end else begin
                        state_nxt = st_req;
                    end
                end
            end
            st_req: begin
                // hold the request until the bus takes the address
                if (rd_ack) begin
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                // foreign ids are fetch traffic, just drop them
                if (rsp_hit) begin
                    state_nxt = st_done;
                end
            end
            st_done: begin
                state_nxt = st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // op is taken in idle only, one op in flight
    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid) begin
            op_q <= req;
        end
        if (rsp_hit) begin
            beat_q <= rd_rsp.data;
        end
    end

    // request address dropped to the doubleword boundary
    assign rd_req.addr  = {op_q.addr[lsu_pkg::xlen-1:lsu_pkg::off_w], {lsu_pkg::off_w{1'b0}}};
    assign rd_req.id    = lsu_pkg::mem_id;
    assign rd_req_valid = (state == st_req);

    // busy covers the req_valid cycle too, the fsm is still idle there
    assign busy = req_valid || (state != st_idle);
    assign done = (state == st_done);
    assign beat = beat_q;
    assign op   = op_q;

endmodule

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // datapath and address width
    localparam int xlen = 64;

    // read bus id width
    localparam int id_w = 4;

    // id this stage puts on requests
    // fetch shares the bus with its own ids
    localparam logic [id_w-1:0] mem_id = 2;

    // byte offset bits inside one 64-bit beat
    localparam int off_w = 3;

    // load kinds
    // none marks an op that only carries an alu result
    typedef enum logic [2:0] {
        lb   = 3'd0,
        lh   = 3'd1,
        lw   = 3'd2,
        ld   = 3'd3,
        lbu  = 3'd4,
        lhu  = 3'd5,
        lwu  = 3'd6,
        none = 3'd7
    } load_kind_t;

    // op as handed over by execute
    typedef struct packed {
        load_kind_t      kind;
        logic [xlen-1:0] base;
        logic [xlen-1:0] offset;
        logic [xlen-1:0] alu_res;
    } ex_op_t;

    // op after capture, address already summed
    typedef struct packed {
        load_kind_t      kind;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] alu_res;
    } mem_op_t;

    // read request on the shared bus
    // addr is always doubleword aligned
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [id_w-1:0] id;
    } rd_req_t;

    // read response, one full beat
    typedef struct packed {
        logic [xlen-1:0] data;
        logic [id_w-1:0] id;
    } rd_rsp_t;

    // writeback record
    typedef struct packed {
        logic [xlen-1:0] data;
        logic            from_mem;
    } wb_t;

endpackage

`default_nettype wire

// ==== rtl/mem_req_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_req_capture (
    input  wire logic            clk,
    input  wire logic            rst_n,
    // one-cycle strobe from execute
    input  wire logic            ex_valid,
    input  wire lsu_pkg::ex_op_t ex_op,
    // one-cycle pulse toward the sequencer
    output logic                 req_valid,
    output lsu_pkg::mem_op_t     req
);

    // effective address, base plus offset
    logic [lsu_pkg::xlen-1:0] eff_addr;

    // captured op before the register
    lsu_pkg::mem_op_t op_in;

    // adder sits in front of the capture flop
    assign eff_addr = ex_op.base + ex_op.offset;

    // repack into the captured shape
    always_comb begin
        op_in.kind    = ex_op.kind;
        op_in.addr    = eff_addr;
        op_in.alu_res = ex_op.alu_res;
    end

    // strobe follows ex_valid by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= ex_valid;
        end
    end

    // payload only loads on a new op
    // holds otherwise, sequencer samples it with req_valid
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            req <= op_in;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  wire logic             clk,
    input  wire logic             rst_n,
    // execute side
    input  wire logic             ex_valid,
    input  wire lsu_pkg::ex_op_t  ex_op,
    output logic                  busy,
    // shared read bus
    output logic                  rd_req_valid,
    output lsu_pkg::rd_req_t      rd_req,
    input  wire logic             rd_ack,
    input  wire logic             rd_rsp_valid,
    input  wire lsu_pkg::rd_rsp_t rd_rsp,
    // writeback side
    output logic                  wb_valid,
    output lsu_pkg::wb_t          wb
);

    // capture to sequencer
    logic             req_valid;
    lsu_pkg::mem_op_t req;

    // sequencer to extend
    logic                     done;
    logic [lsu_pkg::xlen-1:0] beat;
    lsu_pkg::mem_op_t         op;

    mem_req_capture u_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .ex_op     (ex_op),
        .req_valid (req_valid),
        .req       (req)
    );

    load_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req          (req),
        .rd_req_valid (rd_req_valid),
        .rd_req       (rd_req),
        .rd_ack       (rd_ack),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp       (rd_rsp),
        .busy         (busy),
        .done         (done),
        .beat         (beat),
        .op           (op)
    );

    // lane select and extension, purely combinational
    load_extend u_extend (
        .done     (done),
        .op       (op),
        .beat     (beat),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

endmodule

`default_nettype wire
